// ==== design/tqv_periph_macros.svh ====
/*
 * Peripheral address map and sizing
 * Slot and pin counts, GPIO register offsets and address field positions
 */

`ifndef TQV_PERIPH_MACROS_SVH
`define TQV_PERIPH_MACROS_SVH

// Sizing
`define TQV_NUM_SLOTS       16
`define TQV_NUM_PINS        8

// User peripheral index of the GPIO block
`define TQV_PERI_GPIO       1

// GPIO register offsets
`define TQV_GPIO_OUT_OFS    6'h00
`define TQV_GPIO_IN_OFS     6'h04
// One word per pin from here on
`define TQV_FUNC_SEL_BASE   6'h20

// Set for the byte-only slots
`define TQV_SIMPLE_BIT      10

// Address fields
`define TQV_USER_IDX_HI     9
`define TQV_USER_IDX_LO     6
`define TQV_SLOT_IDX_HI     7
`define TQV_SLOT_IDX_LO     4
`define TQV_REG_OFS_HI      5
`define TQV_REG_OFS_LO      0

`endif

// ==== design/tqv_periph_pkg.sv ====
/*
 * Peripheral bus package
 * Shared types for bus words, access size codes, slot indices and pin functions
 */

`default_nettype none

package tqv_periph_pkg;

    // 32-bit bus data word
    typedef logic [31:0] word_t;

    // Pin vector or byte slot register
    typedef logic [7:0] byte_t;

    // Active-low size codes from the core, all ones means idle
    typedef enum logic [1:0] {
        ACC_BYTE = 2'b00,
        ACC_HALF = 2'b01,
        ACC_WORD = 2'b10,
        ACC_NONE = 2'b11
    } access_t;

    // Peripheral address as seen by this block
    typedef logic [10:0] addr_t;

    // Index of a user peripheral or byte slot
    typedef logic [3:0] slot_idx_t;

    // Output pin function
    // is_slot picks a byte slot, otherwise idx names a user peripheral
    typedef struct packed {
        logic      is_slot;
        slot_idx_t idx;
    } func_sel_t;

endpackage : tqv_periph_pkg

`default_nettype wire

// ==== design/tqv_bus_ctrl.sv ====
/*
 * Peripheral bus controller
 * Decodes the address into write strobes, muxes the read source and holds
 * the registered read data until the core reports the read complete
 */

`default_nettype none

`include "tqv_periph_macros.svh"

module tqv_bus_ctrl (
    input  wire                      clk,
    input  wire                      rst_n,
    input  tqv_periph_pkg::addr_t    i_addr,
    input  tqv_periph_pkg::access_t  i_data_write_n,
    input  tqv_periph_pkg::access_t  i_data_read_n,
    input  wire                      i_data_read_complete,
    input  tqv_periph_pkg::word_t    i_gpio_rdata,
    input  tqv_periph_pkg::byte_t    i_slot_rdata,
    output logic                     o_gpio_we,
    output logic                     o_slot_we,
    output tqv_periph_pkg::word_t    o_data,
    output logic                     o_data_ready
);

    import tqv_periph_pkg::*;

    logic      is_simple;
    slot_idx_t user_idx;
    logic      write_req;
    logic      read_req;
    logic      capture;
    word_t     periph_rdata;
    logic      hold;
    logic      ready_r;

    assign is_simple = i_addr[`TQV_SIMPLE_BIT];
    assign user_idx  = i_addr[`TQV_USER_IDX_HI:`TQV_USER_IDX_LO];
    assign write_req = (i_data_write_n != ACC_NONE);
    assign read_req  = (i_data_read_n != ACC_NONE);

    // Size is not needed downstream, any write becomes one enable
    assign o_gpio_we = write_req && !is_simple && (user_idx == slot_idx_t'(`TQV_PERI_GPIO));
    assign o_slot_we = write_req && is_simple;

    // Every source answers at once; empty user slots read zero
    always_comb begin
        if (is_simple) begin
            periph_rdata = {24'h0, i_slot_rdata};
        end else if (user_idx == slot_idx_t'(`TQV_PERI_GPIO)) begin
            periph_rdata = i_gpio_rdata;
        end else begin
            periph_rdata = '0;
        end
    end

    // Reads are masked while ready is up so a held request is taken once
    assign capture = read_req && !ready_r && !hold;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold    <= 1'b0;
            ready_r <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                hold <= 1'b0;
            end
            if (capture) begin
                hold <= 1'b1;
            end
            ready_r <= read_req;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            o_data <= periph_rdata;
        end
    end

    // Writes complete in the cycle they are issued
    assign o_data_ready = ready_r || write_req;

endmodule : tqv_bus_ctrl

`default_nettype wire

// ==== design/tqv_gpio.sv ====
/*
 * GPIO peripheral
 * Output register, input pin readback and one function select per output pin
 */

`default_nettype none

`include "tqv_periph_macros.svh"

module tqv_gpio (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        i_we,
    input  tqv_periph_pkg::addr_t      i_addr,
    input  tqv_periph_pkg::word_t      i_data,
    input  tqv_periph_pkg::byte_t      i_ui,
    output tqv_periph_pkg::word_t      o_rdata,
    output tqv_periph_pkg::byte_t      o_gpio_out,
    output tqv_periph_pkg::func_sel_t  o_func_sel [`TQV_NUM_PINS]
);

    import tqv_periph_pkg::*;

    localparam int SEL_W = $clog2(`TQV_NUM_PINS);

    localparam func_sel_t FUNC_GPIO = '{is_slot: 1'b0, idx: slot_idx_t'(`TQV_PERI_GPIO)};

    logic [5:0]       reg_ofs;
    logic [5:0]       fsel_rel;
    logic             fsel_hit;
    logic [SEL_W-1:0] fsel_idx;

    assign reg_ofs  = i_addr[`TQV_REG_OFS_HI:`TQV_REG_OFS_LO];
    assign fsel_rel = reg_ofs - `TQV_FUNC_SEL_BASE;

    // Word-aligned slot in the function select window
    assign fsel_hit = (reg_ofs >= `TQV_FUNC_SEL_BASE) && (fsel_rel[1:0] == 2'b00);
    assign fsel_idx = fsel_rel[SEL_W+1:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_gpio_out <= '0;
            for (int p = 0; p < `TQV_NUM_PINS; p++) begin
                o_func_sel[p] <= FUNC_GPIO;
            end
        end else if (i_we) begin
            if (reg_ofs == `TQV_GPIO_OUT_OFS) begin
                o_gpio_out <= i_data[7:0];
            end
            if (fsel_hit) begin
                o_func_sel[fsel_idx] <= func_sel_t'(i_data[4:0]);
            end
        end
    end

    // Readback
    always_comb begin
        o_rdata = '0;
        if (reg_ofs == `TQV_GPIO_OUT_OFS) begin
            o_rdata = {24'h0, o_gpio_out};
        end else if (reg_ofs == `TQV_GPIO_IN_OFS) begin
            o_rdata = {24'h0, i_ui};
        end else if (fsel_hit) begin
            o_rdata = {27'h0, o_func_sel[fsel_idx]};
        end
    end

endmodule : tqv_gpio

`default_nettype wire

// ==== design/tqv_byte_slots.sv ====
/*
 * Byte peripheral slot bank
 * One 8-bit register per slot at offset 0, read back and driven onto its pins
 */

`default_nettype none

`include "tqv_periph_macros.svh"

module tqv_byte_slots (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    i_we,
    input  tqv_periph_pkg::addr_t  i_addr,
    input  tqv_periph_pkg::byte_t  i_data,
    output tqv_periph_pkg::byte_t  o_rdata,
    output tqv_periph_pkg::byte_t  o_slot_pins [`TQV_NUM_SLOTS]
);

    import tqv_periph_pkg::*;

    slot_idx_t slot_sel;
    logic      at_reg0;

    assign slot_sel = i_addr[`TQV_SLOT_IDX_HI:`TQV_SLOT_IDX_LO];
    // Offset within the 16-byte slot window
    assign at_reg0  = (i_addr[`TQV_SLOT_IDX_LO-1:0] == '0);

    // Each slot register is its pin vector
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `TQV_NUM_SLOTS; s++) begin
                o_slot_pins[s] <= '0;
            end
        end else if (i_we && at_reg0) begin
            o_slot_pins[slot_sel] <= i_data;
        end
    end

    assign o_rdata = at_reg0 ? o_slot_pins[slot_sel] : '0;

endmodule : tqv_byte_slots

`default_nettype wire

// ==== design/tqv_pin_router.sv ====
/*
 * Output pin router
 * Gives each output pin to the GPIO block or a byte slot by its function select
 */

`default_nettype none

`include "tqv_periph_macros.svh"

module tqv_pin_router (
    input  tqv_periph_pkg::func_sel_t  i_func_sel [`TQV_NUM_PINS],
    input  tqv_periph_pkg::byte_t      i_gpio_out,
    input  tqv_periph_pkg::byte_t      i_slot_pins [`TQV_NUM_SLOTS],
    output tqv_periph_pkg::byte_t      o_uo
);

    // Pin p always takes bit p of whichever source it selects
    always_comb begin
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            if (i_func_sel[p].is_slot) begin
                o_uo[p] = i_slot_pins[i_func_sel[p].idx][p];
            end else if (i_func_sel[p].idx == 4'(`TQV_PERI_GPIO)) begin
                o_uo[p] = i_gpio_out[p];
            end else begin
                // No other user peripheral drives pins
                o_uo[p] = 1'b0;
            end
        end
    end

endmodule : tqv_pin_router

`default_nettype wire

// ==== design/tqv_periph_top.sv ====
/*
 * Peripheral block top level
 * Bus controller, GPIO, byte slot bank and output pin router
 */

`default_nettype none

`include "tqv_periph_macros.svh"

module tqv_periph_top (
    input  wire                      clk,
    input  wire                      rst_n,
    input  tqv_periph_pkg::byte_t    i_ui,
    output tqv_periph_pkg::byte_t    o_uo,
    input  tqv_periph_pkg::addr_t    i_addr,
    input  tqv_periph_pkg::word_t    i_data,
    input  tqv_periph_pkg::access_t  i_data_write_n,
    input  tqv_periph_pkg::access_t  i_data_read_n,
    input  wire                      i_data_read_complete,
    output tqv_periph_pkg::word_t    o_data,
    output logic                     o_data_ready
);

    import tqv_periph_pkg::*;

    logic      gpio_we;
    logic      slot_we;
    word_t     gpio_rdata;
    byte_t     slot_rdata;
    byte_t     gpio_out;
    func_sel_t func_sel [`TQV_NUM_PINS];
    byte_t     slot_pins [`TQV_NUM_SLOTS];

    tqv_bus_ctrl u_bus_ctrl (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .i_gpio_rdata         (gpio_rdata),
        .i_slot_rdata         (slot_rdata),
        .o_gpio_we            (gpio_we),
        .o_slot_we            (slot_we),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready)
    );

    tqv_gpio u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_we       (gpio_we),
        .i_addr     (i_addr),
        .i_data     (i_data),
        .i_ui       (i_ui),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (gpio_out),
        .o_func_sel (func_sel)
    );

    // Byte slots only see the low byte of the bus
    tqv_byte_slots u_byte_slots (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_we        (slot_we),
        .i_addr      (i_addr),
        .i_data      (i_data[7:0]),
        .o_rdata     (slot_rdata),
        .o_slot_pins (slot_pins)
    );

    tqv_pin_router u_pin_router (
        .i_func_sel  (func_sel),
        .i_gpio_out  (gpio_out),
        .i_slot_pins (slot_pins),
        .o_uo        (o_uo)
    );

endmodule : tqv_periph_top

`default_nettype wire

// ==== testbench/tqv_periph_checker.sv ====
/*
 * Bus protocol checker
 * Concurrent assertions on write ready, read return timing and held read data
 */

`default_nettype none

module tqv_periph_checker (
    input  wire                      clk,
    input  wire                      rst_n,
    input  tqv_periph_pkg::access_t  i_data_write_n,
    input  tqv_periph_pkg::access_t  i_data_read_n,
    input  wire                      i_data_read_complete,
    input  tqv_periph_pkg::word_t    o_data,
    input  wire                      o_data_ready
);

    import tqv_periph_pkg::*;

    logic write_req;
    logic read_req;

    assign write_req = (i_data_write_n != ACC_NONE);
    assign read_req  = (i_data_read_n != ACC_NONE);

    // Writes never wait
    write_ready_a: assert property (@(posedge clk) disable iff (!rst_n)
        write_req |-> o_data_ready)
        else $error("write seen without data ready");

    // A new read is answered exactly one cycle later
    read_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(read_req) && !write_req |-> !o_data_ready ##1 o_data_ready)
        else $error("read data ready not one cycle after the request");

    // Captured data holds until the core takes it
    read_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        o_data_ready && !write_req && !i_data_read_complete |=> $stable(o_data))
        else $error("read data changed before read complete");

    read_release_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(read_req) |=> (o_data_ready == write_req))
        else $error("data ready still high after the read was withdrawn");

endmodule : tqv_periph_checker

bind tqv_periph_top tqv_periph_checker u_checker (
    .clk                  (clk),
    .rst_n                (rst_n),
    .i_data_write_n       (i_data_write_n),
    .i_data_read_n        (i_data_read_n),
    .i_data_read_complete (i_data_read_complete),
    .o_data               (o_data),
    .o_data_ready         (o_data_ready)
);

`default_nettype wire

// ==== testbench/tqv_periph_tb.sv ====
/*
 * Testbench for the peripheral block
 * Drives the core bus, keeps a model of the registers and checks reads and pins
 */

`default_nettype none

`include "tqv_periph_macros.svh"

module tqv_periph_tb;

    import tqv_periph_pkg::*;

    localparam int PERIOD = 40;
    // Reset 26, GPIO 12, input 6, slots 48, routing 80, unused user slots 15
    localparam int N_TRANS = 26 + 12 + 6 + 48 + 80 + 15;
    localparam int TIMEOUT = (N_TRANS * 10 + 100) * PERIOD;

    logic    clk = 1'b0;
    logic    rst_n;
    byte_t   i_ui;
    byte_t   o_uo;
    addr_t   i_addr;
    word_t   i_data;
    access_t i_data_write_n;
    access_t i_data_read_n;
    logic    i_data_read_complete;
    word_t   o_data;
    logic    o_data_ready;

    integer     seed;
    word_t      wval;
    byte_t      gpio_model;
    logic [4:0] fsel_model [`TQV_NUM_PINS];
    byte_t      slot_model [`TQV_NUM_SLOTS];

    tqv_periph_top dut (.*);

    always #(PERIOD / 2) clk = ~clk;

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_eq(input string what, input word_t got, input word_t exp);
        assert (got == exp) else
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    endtask

    function automatic addr_t user_addr(input int idx, input int ofs);
        return addr_t'((idx << `TQV_USER_IDX_LO) | ofs);
    endfunction

    function automatic addr_t slot_addr(input int s, input int ofs);
        return addr_t'((1 << `TQV_SIMPLE_BIT) | (s << `TQV_SLOT_IDX_LO) | ofs);
    endfunction

    // Routing rule applied to the model
    function automatic byte_t expected_uo();
        byte_t v;
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            if (fsel_model[p][4]) begin
                v[p] = slot_model[fsel_model[p][3:0]][p];
            end else if (fsel_model[p][3:0] == 4'd1) begin
                v[p] = gpio_model[p];
            end else begin
                v[p] = 1'b0;
            end
        end
        return v;
    endfunction

    // Counts falling edges until ready shows up
    task automatic wait_ready(output int edges);
        edges = 0;
        do begin
            @(negedge clk);
            edges++;
        end while (!o_data_ready && edges < 16);
        if (!o_data_ready) begin
            fail_run($sformatf("DUT gave no data ready within 16 cycles at %0t", $time));
        end
    endtask

    task automatic bus_write(input addr_t addr, input word_t data, input access_t size);
        int edges;
        i_addr = addr;
        i_data = data;
        i_data_write_n = size;
        wait_ready(edges);
        @(posedge clk);
        #2;
        i_data_write_n = ACC_NONE;
    endtask

    task automatic read_and_check(input string what, input addr_t addr, input word_t exp);
        int    edges;
        word_t got;
        i_addr = addr;
        i_data_read_n = ACC_WORD;
        wait_ready(edges);
        // One cycle of latency shows up as the second falling edge
        check_eq({what, " latency"}, word_t'(edges), 32'd2);
        got = o_data;
        @(posedge clk);
        #2;
        i_data_read_n = ACC_NONE;
        i_data_read_complete = 1'b1;
        @(posedge clk);
        #2;
        i_data_read_complete = 1'b0;
        check_eq(what, got, exp);
    endtask

    // Holds a read of the input pins while they move, then reissues it
    // before read complete; the first captured value must stay on o_data
    task automatic held_read_check();
        int    edges;
        byte_t first;
        first = byte_t'($random(seed));
        i_ui = first;
        i_addr = user_addr(`TQV_PERI_GPIO, `TQV_GPIO_IN_OFS);
        i_data_read_n = ACC_WORD;
        wait_ready(edges);
        check_eq("held read latency", word_t'(edges), 32'd2);
        @(posedge clk);
        #2;
        i_ui = ~first;
        repeat (3) begin
            @(negedge clk);
            check_eq("held read ready", word_t'(o_data_ready), 32'd1);
            check_eq("held read", o_data, word_t'(first));
            @(posedge clk);
            #2;
        end
        // Withdraw without read complete, then ask again
        i_data_read_n = ACC_NONE;
        @(posedge clk);
        #2;
        i_data_read_n = ACC_WORD;
        wait_ready(edges);
        check_eq("reissued read latency", word_t'(edges), 32'd2);
        check_eq("reissued read", o_data, word_t'(first));
        @(posedge clk);
        #2;
        i_data_read_n = ACC_NONE;
        i_data_read_complete = 1'b1;
        @(posedge clk);
        #2;
        i_data_read_complete = 1'b0;
    endtask

    task automatic check_pins();
        @(negedge clk);
        check_eq("o_uo", word_t'(o_uo), word_t'(expected_uo()));
        @(posedge clk);
        #2;
    endtask

    initial begin
        #(TIMEOUT);
        fail_run($sformatf("watchdog expired at %0t before the tests finished", $time));
    end

    initial begin
        seed = 32'h9b59;
        rst_n = 1'b0;
        i_ui = '0;
        i_addr = '0;
        i_data = '0;
        i_data_write_n = ACC_NONE;
        i_data_read_n = ACC_NONE;
        i_data_read_complete = 1'b0;
        gpio_model = '0;
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            fsel_model[p] = 5'd1;
        end
        for (int s = 0; s < `TQV_NUM_SLOTS; s++) begin
            slot_model[s] = '0;
        end
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Reset state
        read_and_check("gpio out", user_addr(1, 'h00), '0);
        for (int p = 0; p < `TQV_NUM_PINS; p++) begin
            read_and_check($sformatf("func sel %0d", p), user_addr(1, 'h20 + 4 * p), 32'd1);
        end
        for (int s = 0; s < `TQV_NUM_SLOTS; s++) begin
            read_and_check($sformatf("slot %0d", s), slot_addr(s, 0), '0);
        end
        check_pins();

        // GPIO output with default selects
        repeat (4) begin
            wval = $random(seed);
            bus_write(user_addr(1, 'h00), wval, ACC_WORD);
            gpio_model = wval[7:0];
            read_and_check("gpio out", user_addr(1, 'h00), word_t'(gpio_model));
            check_pins();
        end

        held_read_check();
        repeat (4) begin
            i_ui = byte_t'($random(seed));
            read_and_check("gpio in", user_addr(1, 'h04), word_t'(i_ui));
        end

        for (int s = 0; s < `TQV_NUM_SLOTS; s++) begin
            slot_model[s] = byte_t'($random(seed));
            bus_write(slot_addr(s, 0), word_t'(slot_model[s]), ACC_BYTE);
        end
        for (int s = 0; s < `TQV_NUM_SLOTS; s++) begin
            read_and_check($sformatf("slot %0d", s), slot_addr(s, 0), word_t'(slot_model[s]));
            read_and_check($sformatf("slot %0d upper offset", s),
                           slot_addr(s, 1 + (($random(seed) & 32'hff) % 15)), '0);
        end

        // Random function selects cover slots, GPIO and idle user indices
        repeat (8) begin
            for (int p = 0; p < `TQV_NUM_PINS; p++) begin
                fsel_model[p] = 5'($random(seed));
                bus_write(user_addr(1, 'h20 + 4 * p), word_t'(fsel_model[p]), ACC_WORD);
            end
            read_and_check("func sel 3", user_addr(1, 'h2c), word_t'(fsel_model[3]));
            check_pins();
        end

        for (int idx = 0; idx < `TQV_NUM_SLOTS; idx++) begin
            if (idx != `TQV_PERI_GPIO) begin
                read_and_check($sformatf("user slot %0d", idx), user_addr(idx, 'h00), '0);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tqv_periph_tb

`default_nettype wire

// ==== tqv_periph.f ====
+incdir+design
design/tqv_periph_pkg.sv
design/tqv_bus_ctrl.sv
design/tqv_gpio.sv
design/tqv_byte_slots.sv
design/tqv_pin_router.sv
design/tqv_periph_top.sv
testbench/tqv_periph_checker.sv
testbench/tqv_periph_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tqv_periph_tb
FILELIST := tqv_periph.f
BUILD    := obj_dir
LOG      := sim.log
FAIL_MSG := TEST RESULT: FAIL
PASS_MSG := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a pass report"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
